// ==== match_config.svh ====
`ifndef MATCH_CONFIG_SVH
`define MATCH_CONFIG_SVH

// --------------------------------------------------
// board geometry
// --------------------------------------------------
`define BOARD_DIM 8
`define CELL_PX 32

// screen position of the top left board corner
`define BOARD_X0 272
`define BOARD_Y0 112

// cursor frame thickness in pixels
`define CURSOR_PX 2

// --------------------------------------------------
// 12-bit rgb colours
// --------------------------------------------------
`define COLOR_BLANK 12'h000
`define COLOR_BACK 12'hfff
`define COLOR_CURSOR 12'hff0
`define COLOR_SELECT 12'hf00

// symbol palette, one entry per cell value 0 to 4
`define COLOR_SYM0 12'h00f
`define COLOR_SYM1 12'h0a0
`define COLOR_SYM2 12'hf0f
`define COLOR_SYM3 12'h0ff
`define COLOR_SYM4 12'hf80

// start value of the random source, must not be zero
`define LFSR_SEED 16'hace1

`endif

// ==== match_pkg.sv ====
`include "match_config.svh"

package match_pkg;

    // cell contents, 0 to 4 are symbols
    typedef logic [2:0] cell_t;

    // marks a cell cleared by a match
    localparam cell_t CELL_EMPTY = 3'd7;

    // row or column index
    typedef logic [2:0] coord_t;

    typedef enum logic [1:0] {
        DIR_LEFT,
        DIR_RIGHT,
        DIR_UP,
        DIR_DOWN
    } move_dir_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_FILL,
        CMD_SWAP
    } board_cmd_t;

    typedef enum logic [1:0] {
        ST_MOVE,
        ST_SELECTED,
        ST_FILL
    } ctrl_state_t;

    // whole board, indexed [row][col]
    typedef cell_t [`BOARD_DIM-1:0][`BOARD_DIM-1:0] board_t;

endpackage

// ==== input_controller.sv ====
`timescale 1ns/1ps
`include "match_config.svh"

module input_controller import match_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       left,
    input  logic       right,
    input  logic       up,
    input  logic       down,
    input  logic       enter,
    input  logic       game_reset,
    output board_cmd_t cmd,
    output coord_t     cmd_row,
    output coord_t     cmd_col,
    output move_dir_t  cmd_dir,
    output cell_t      cmd_value,
    output coord_t     cur_row,
    output coord_t     cur_col,
    output logic       selected,
    output logic       board_ready
);

    localparam coord_t     COORD_MAX  = coord_t'(`BOARD_DIM - 1);
    localparam logic [6:0] FILL_TOTAL = 7'(`BOARD_DIM * `BOARD_DIM);
    localparam cell_t      SYM_LIMIT  = 3'd5;

    ctrl_state_t state;
    ctrl_state_t state_next;
    coord_t      row_next;
    coord_t      col_next;
    logic [6:0]  fill_cnt;
    logic [6:0]  fill_next;
    board_cmd_t  cmd_next;
    logic [15:0] lfsr;
    cell_t       rand_val;
    logic        rand_ok;
    move_dir_t   move_dir;
    logic        move_req;
    logic        move_ok;

    // --------------------------------------------------
    // random source
    // --------------------------------------------------
    // free running, so the board depends on when a fill starts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // low three bits minus one, values past the last symbol are dropped
    assign rand_val = lfsr[2:0] - 3'd1;
    assign rand_ok  = rand_val < SYM_LIMIT;

    // --------------------------------------------------
    // direction decode
    // --------------------------------------------------
    always_comb begin
        move_req = 1'b1;
        move_dir = DIR_LEFT;
        if (left)
            move_dir = DIR_LEFT;
        else if (right)
            move_dir = DIR_RIGHT;
        else if (up)
            move_dir = DIR_UP;
        else if (down)
            move_dir = DIR_DOWN;
        else
            move_req = 1'b0;
    end

    // edge check, the board store relies on this
    always_comb begin
        case (move_dir)
            DIR_LEFT:  move_ok = move_req && (cur_col != 3'd0);
            DIR_RIGHT: move_ok = move_req && (cur_col != COORD_MAX);
            DIR_UP:    move_ok = move_req && (cur_row != 3'd0);
            default:   move_ok = move_req && (cur_row != COORD_MAX);
        endcase
    end

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        row_next   = cur_row;
        col_next   = cur_col;
        fill_next  = fill_cnt;
        cmd_next   = CMD_NONE;
        if (state == ST_FILL) begin
            // one idle cycle after the last write so the board is complete
            if (fill_cnt == FILL_TOTAL) begin
                state_next = ST_MOVE;
            end else if (rand_ok) begin
                cmd_next  = CMD_FILL;
                fill_next = fill_cnt + 7'd1;
            end
        end else if (enter) begin
            state_next = (state == ST_MOVE) ? ST_SELECTED : ST_MOVE;
        end else if (game_reset) begin
            state_next = ST_FILL;
            fill_next  = '0;
        end else if (move_ok) begin
            if (state == ST_MOVE) begin
                case (move_dir)
                    DIR_LEFT:  col_next = cur_col - 3'd1;
                    DIR_RIGHT: col_next = cur_col + 3'd1;
                    DIR_UP:    row_next = cur_row - 3'd1;
                    default:   row_next = cur_row + 3'd1;
                endcase
            end else begin
                cmd_next   = CMD_SWAP;
                state_next = ST_MOVE;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_MOVE;
            cur_row  <= '0;
            cur_col  <= '0;
            fill_cnt <= '0;
            cmd      <= CMD_NONE;
        end else begin
            state    <= state_next;
            cur_row  <= row_next;
            cur_col  <= col_next;
            fill_cnt <= fill_next;
            cmd      <= cmd_next;
        end
    end

    // command payload, only looked at when cmd is not CMD_NONE
    // fill order is column major, row index counts fastest
    always_ff @(posedge clk) begin
        cmd_row   <= (state == ST_FILL) ? fill_cnt[2:0] : cur_row;
        cmd_col   <= (state == ST_FILL) ? fill_cnt[5:3] : cur_col;
        cmd_dir   <= move_dir;
        cmd_value <= rand_val;
    end

    assign selected    = (state == ST_SELECTED);
    assign board_ready = (state != ST_FILL);

endmodule

// ==== board_store.sv ====
`timescale 1ns/1ps
`include "match_config.svh"

module board_store import match_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  board_cmd_t cmd,
    input  coord_t     cmd_row,
    input  coord_t     cmd_col,
    input  move_dir_t  cmd_dir,
    input  cell_t      cmd_value,
    output board_t     board
);

    localparam int DIM = `BOARD_DIM;

    coord_t                  nb_row;
    coord_t                  nb_col;
    board_t                  trial;
    board_t                  cleared;
    logic [DIM-1:0][DIM-1:0] mark;
    logic                    any_mark;

    // three equal symbols in a row, empty cells never match
    function automatic logic is_run(input cell_t a, input cell_t b, input cell_t c);
        return (a != CELL_EMPTY) && (a == b) && (b == c);
    endfunction

    // --------------------------------------------------
    // swap trial
    // --------------------------------------------------
    // neighbour of the origin, already known to be on the board
    always_comb begin
        nb_row = cmd_row;
        nb_col = cmd_col;
        case (cmd_dir)
            DIR_LEFT:  nb_col = cmd_col - 3'd1;
            DIR_RIGHT: nb_col = cmd_col + 3'd1;
            DIR_UP:    nb_row = cmd_row - 3'd1;
            default:   nb_row = cmd_row + 3'd1;
        endcase
    end

    always_comb begin
        trial = board;
        trial[cmd_row][cmd_col] = board[nb_row][nb_col];
        trial[nb_row][nb_col] = board[cmd_row][cmd_col];
    end

    // mark every cell covered by a run, runs may overlap
    always_comb begin
        mark = '0;
        // horizontal
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM - 2; c++) begin
                if (is_run(trial[r][c], trial[r][c+1], trial[r][c+2])) begin
                    mark[r][c] = 1'b1;
                    mark[r][c+1] = 1'b1;
                    mark[r][c+2] = 1'b1;
                end
            end
        end
        // vertical
        for (int r = 0; r < DIM - 2; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (is_run(trial[r][c], trial[r+1][c], trial[r+2][c])) begin
                    mark[r][c] = 1'b1;
                    mark[r+1][c] = 1'b1;
                    mark[r+2][c] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        cleared = trial;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (mark[r][c])
                    cleared[r][c] = CELL_EMPTY;
            end
        end
    end

    assign any_mark = |mark;

    // --------------------------------------------------
    // board register
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    board[r][c] <= CELL_EMPTY;
                end
            end
        end else begin
            case (cmd)
                CMD_FILL: board[cmd_row][cmd_col] <= cmd_value;
                // a swap without any run leaves the board as it was
                CMD_SWAP: begin
                    if (any_mark)
                        board <= cleared;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== pixel_renderer.sv ====
`timescale 1ns/1ps
`include "match_config.svh"

module pixel_renderer import match_pkg::*; (
    input  logic        video_on,
    input  logic [9:0]  pix_x,
    input  logic [9:0]  pix_y,
    input  board_t      board,
    input  coord_t      cur_row,
    input  coord_t      cur_col,
    input  logic        selected,
    output logic [11:0] graph_rgb
);

    localparam logic [9:0] X0      = 10'(`BOARD_X0);
    localparam logic [9:0] Y0      = 10'(`BOARD_Y0);
    localparam logic [9:0] CELL_W  = 10'(`CELL_PX);
    localparam logic [9:0] SPAN    = 10'(`BOARD_DIM * `CELL_PX);
    localparam logic [9:0] EDGE_LO = 10'(`CURSOR_PX);
    localparam logic [9:0] EDGE_HI = 10'(`CELL_PX - `CURSOR_PX);

    logic [9:0] off_x;
    logic [9:0] off_y;
    logic [9:0] quot_x;
    logic [9:0] quot_y;
    logic [9:0] in_x;
    logic [9:0] in_y;
    logic       in_board;
    logic       on_border;
    coord_t     cell_row;
    coord_t     cell_col;

    function automatic logic [11:0] palette(input cell_t v);
        case (v)
            3'd0:    return `COLOR_SYM0;
            3'd1:    return `COLOR_SYM1;
            3'd2:    return `COLOR_SYM2;
            3'd3:    return `COLOR_SYM3;
            3'd4:    return `COLOR_SYM4;
            default: return `COLOR_BACK;
        endcase
    endfunction

    // position relative to the board corner
    assign off_x    = pix_x - X0;
    assign off_y    = pix_y - Y0;
    assign in_board = (pix_x >= X0) && (off_x < SPAN) && (pix_y >= Y0) && (off_y < SPAN);

    // cell index and offset inside that cell
    assign quot_x   = off_x / CELL_W;
    assign quot_y   = off_y / CELL_W;
    assign in_x     = off_x % CELL_W;
    assign in_y     = off_y % CELL_W;
    assign cell_col = quot_x[2:0];
    assign cell_row = quot_y[2:0];

    // frame around the cursor cell
    assign on_border = in_board && (cell_row == cur_row) && (cell_col == cur_col) &&
                       ((in_x < EDGE_LO) || (in_x >= EDGE_HI) ||
                        (in_y < EDGE_LO) || (in_y >= EDGE_HI));

    always_comb begin
        if (!video_on)
            graph_rgb = `COLOR_BLANK;
        else if (on_border)
            graph_rgb = selected ? `COLOR_SELECT : `COLOR_CURSOR;
        else if (in_board)
            graph_rgb = palette(board[cell_row][cell_col]);
        else
            graph_rgb = `COLOR_BACK;
    end

endmodule

// ==== match_top.sv ====
`timescale 1ns/1ps

module match_top import match_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        left,
    input  logic        right,
    input  logic        up,
    input  logic        down,
    input  logic        enter,
    input  logic        game_reset,
    input  logic        video_on,
    input  logic [9:0]  pix_x,
    input  logic [9:0]  pix_y,
    output logic [11:0] graph_rgb,
    output logic        board_ready
);

    // board command path
    board_cmd_t cmd;
    coord_t     cmd_row;
    coord_t     cmd_col;
    move_dir_t  cmd_dir;
    cell_t      cmd_value;

    // display state
    coord_t     cur_row;
    coord_t     cur_col;
    logic       selected;
    board_t     board;

    input_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .left        (left),
        .right       (right),
        .up          (up),
        .down        (down),
        .enter       (enter),
        .game_reset  (game_reset),
        .cmd         (cmd),
        .cmd_row     (cmd_row),
        .cmd_col     (cmd_col),
        .cmd_dir     (cmd_dir),
        .cmd_value   (cmd_value),
        .cur_row     (cur_row),
        .cur_col     (cur_col),
        .selected    (selected),
        .board_ready (board_ready)
    );

    board_store u_board (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_row   (cmd_row),
        .cmd_col   (cmd_col),
        .cmd_dir   (cmd_dir),
        .cmd_value (cmd_value),
        .board     (board)
    );

    pixel_renderer u_render (
        .video_on  (video_on),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .board     (board),
        .cur_row   (cur_row),
        .cur_col   (cur_col),
        .selected  (selected),
        .graph_rgb (graph_rgb)
    );

endmodule

// ==== match_top_asserts.sv ====
`timescale 1ns/1ps
`include "match_config.svh"

module match_top_asserts import match_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        video_on,
    input logic [11:0] graph_rgb,
    input logic        board_ready,
    input logic        game_reset
);

    localparam int FILL_LIMIT = 2000;

    int low_cycles;

    // length of the fill in progress
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            low_cycles <= 0;
        else if (board_ready)
            low_cycles <= 0;
        else
            low_cycles <= low_cycles + 1;
    end

    blank_when_video_off: assert property (@(posedge clk) disable iff (reset)
        !video_on |-> graph_rgb == `COLOR_BLANK)
        else $error("graph_rgb not blank while video_on is low");

    // every fall of board_ready ends in a rise within the bound
    fill_finishes: assert property (@(posedge clk) disable iff (reset)
        low_cycles < FILL_LIMIT)
        else $error("board_ready low for %0d cycles", low_cycles);

    // a fill only starts one edge after a game_reset request
    fill_starts_on_request: assert property (@(posedge clk) disable iff (reset)
        $fell(board_ready) |-> $past(game_reset))
        else $error("board_ready fell without a game_reset request");

endmodule

bind match_top match_top_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .video_on    (video_on),
    .graph_rgb   (graph_rgb),
    .board_ready (board_ready),
    .game_reset  (game_reset)
);

// ==== tb_match_top.sv ====
`timescale 1ns/1ps
`include "match_config.svh"

module tb_match_top import match_pkg::*; ();

    localparam int DIM = `BOARD_DIM;
    localparam int FILL_WAIT = 2000;

    logic        clk;
    logic        reset;
    logic        left;
    logic        right;
    logic        up;
    logic        down;
    logic        enter;
    logic        game_reset;
    logic        video_on;
    logic [9:0]  pix_x;
    logic [9:0]  pix_y;
    logic [11:0] graph_rgb;
    logic        board_ready;

    logic [15:0] rng;
    int          errors;
    int          timeouts;
    int          checks;
    int          exp_row;
    int          exp_col;
    int          commits;
    int          misses;
    int          empties;
    board_t      seen;
    board_t      model;

    match_top uut (
        .clk         (clk),
        .reset       (reset),
        .left        (left),
        .right       (right),
        .up          (up),
        .down        (down),
        .enter       (enter),
        .game_reset  (game_reset),
        .video_on    (video_on),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .graph_rgb   (graph_rgb),
        .board_ready (board_ready)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            rng = lfsr_step(rng);
            value = (value << 1) | int'(rng[0]);
        end
    endtask

    // 5 stands for a colour that is no cell value at all
    function automatic cell_t colour_to_cell(input logic [11:0] rgb);
        case (rgb)
            `COLOR_SYM0: return 3'd0;
            `COLOR_SYM1: return 3'd1;
            `COLOR_SYM2: return 3'd2;
            `COLOR_SYM3: return 3'd3;
            `COLOR_SYM4: return 3'd4;
            `COLOR_BACK: return CELL_EMPTY;
            default:     return 3'd5;
        endcase
    endfunction

    task automatic check_value(input string name, input int got, input int exp_v);
        checks++;
        assert (got == exp_v) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp_v);
            errors++;
        end
    endtask

    task automatic press(input int which);
        @(posedge clk);
        case (which)
            0:       left <= 1'b1;
            1:       right <= 1'b1;
            2:       up <= 1'b1;
            3:       down <= 1'b1;
            4:       enter <= 1'b1;
            default: game_reset <= 1'b1;
        endcase
        @(posedge clk);
        {left, right, up, down, enter, game_reset} <= '0;
        @(negedge clk);
    endtask

    task automatic sample(input int x, input int y, output logic [11:0] rgb);
        @(posedge clk);
        pix_x <= 10'(x);
        pix_y <= 10'(y);
        @(negedge clk);
        rgb = graph_rgb;
    endtask

    // cell interior only, the cursor frame stays outside it
    task automatic read_board(output board_t b);
        logic [11:0] rgb;
        int          jx;
        int          jy;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                take_random(3, jx);
                take_random(3, jy);
                sample(`BOARD_X0 + c * `CELL_PX + 12 + jx,
                       `BOARD_Y0 + r * `CELL_PX + 12 + jy, rgb);
                b[r][c] = colour_to_cell(rgb);
            end
        end
    endtask

    // left frame column of the expected cursor cell
    task automatic check_cursor(input logic [11:0] exp_rgb);
        logic [11:0] rgb;
        int          dx;
        int          dy;
        take_random(1, dx);
        take_random(5, dy);
        sample(`BOARD_X0 + exp_col * `CELL_PX + dx, `BOARD_Y0 + exp_row * `CELL_PX + dy, rgb);
        check_value("graph_rgb at cursor frame", rgb, exp_rgb);
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!board_ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!board_ready) begin
            $display("timeout: board_ready still low after %0d cycles", limit);
            timeouts++;
        end
    endtask

    task automatic move_cursor(input int dir);
        press(dir);
        case (dir)
            0:       if (exp_col > 0) exp_col--;
            1:       if (exp_col < DIM - 1) exp_col++;
            2:       if (exp_row > 0) exp_row--;
            default: if (exp_row < DIM - 1) exp_row++;
        endcase
        check_cursor(`COLOR_CURSOR);
    endtask

    task automatic compare_board(input board_t exp_b, input board_t got_b);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                check_value($sformatf("board[%0d][%0d]", r, c), got_b[r][c], exp_b[r][c]);
            end
        end
    endtask

    task automatic check_filled(input board_t b);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                checks++;
                assert (b[r][c] <= 3'd4) else begin
                    $display("CHECK FAILED board[%0d][%0d] 0x%0h is not a symbol", r, c, b[r][c]);
                    errors++;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // reference rule for a swap attempt
    // --------------------------------------------------
    function automatic board_t swap_model(input board_t b, input int r0, input int c0,
                                          input int r1, input int c1, output bit hit);
        board_t                  t;
        logic [DIM-1:0][DIM-1:0] mk;
        cell_t                   v;
        int                      r2;
        int                      c2;
        t = b;
        t[r0][c0] = b[r1][c1];
        t[r1][c1] = b[r0][c0];
        mk = '0;
        hit = 1'b0;
        // d 0 looks along the row, d 1 down the column
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                for (int d = 0; d < 2; d++) begin
                    r2 = r + 2 * d;
                    c2 = c + 2 * (1 - d);
                    v = t[r][c];
                    if (r2 < DIM && c2 < DIM && v != CELL_EMPTY &&
                        t[r + d][c + 1 - d] == v && t[r2][c2] == v) begin
                        mk[r][c] = 1'b1;
                        mk[r + d][c + 1 - d] = 1'b1;
                        mk[r2][c2] = 1'b1;
                        hit = 1'b1;
                    end
                end
            end
        end
        if (!hit)
            return b;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (mk[r][c])
                    t[r][c] = CELL_EMPTY;
            end
        end
        return t;
    endfunction

    task automatic try_swap();
        int steps;
        int d;
        int dir;
        int nr;
        int nc;
        bit hit;
        take_random(2, steps);
        for (int i = 0; i <= steps; i++) begin
            take_random(2, d);
            move_cursor(d);
        end
        read_board(seen);
        press(4);
        check_cursor(`COLOR_SELECT);
        take_random(2, dir);
        nr = exp_row;
        nc = exp_col;
        case (dir)
            0:       nc = exp_col - 1;
            1:       nc = exp_col + 1;
            2:       nr = exp_row - 1;
            default: nr = exp_row + 1;
        endcase
        if (nr < 0 || nr >= DIM || nc < 0 || nc >= DIM) begin
            // off the board, selection stays
            press(dir);
            check_cursor(`COLOR_SELECT);
            press(4);
            check_cursor(`COLOR_CURSOR);
        end else begin
            model = swap_model(seen, exp_row, exp_col, nr, nc, hit);
            press(dir);
            check_cursor(`COLOR_CURSOR);
            read_board(seen);
            compare_board(model, seen);
            if (hit)
                commits++;
            else
                misses++;
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        {left, right, up, down, enter, game_reset} = '0;
        video_on = 1'b0;
        pix_x = '0;
        pix_y = '0;
        rng = 16'd44433;
        errors = 0;
        timeouts = 0;
        checks = 0;
        commits = 0;
        misses = 0;
        empties = 0;
        exp_row = 0;
        exp_col = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // one cycle of blanking out of reset
        @(posedge clk);
        video_on <= 1'b1;
        @(negedge clk);

        check_value("board_ready", board_ready, 1);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                model[r][c] = CELL_EMPTY;
            end
        end
        read_board(seen);
        compare_board(model, seen);
        check_cursor(`COLOR_CURSOR);

        // fill
        press(5);
        check_value("board_ready", board_ready, 0);
        wait_ready(FILL_WAIT);
        read_board(seen);
        check_filled(seen);

        // cursor walk with clamping
        repeat (24) begin
            int d;
            take_random(2, d);
            move_cursor(d);
        end

        // buttons during a fill are ignored
        press(5);
        check_value("board_ready", board_ready, 0);
        press(1);
        press(3);
        press(4);
        wait_ready(FILL_WAIT);
        check_cursor(`COLOR_CURSOR);
        read_board(seen);
        check_filled(seen);

        // selection, then an edge move while selected
        repeat (DIM) move_cursor(0);
        repeat (DIM) move_cursor(2);
        press(4);
        check_cursor(`COLOR_SELECT);
        press(4);
        check_cursor(`COLOR_CURSOR);
        press(4);
        press(0);
        check_cursor(`COLOR_SELECT);
        press(2);
        check_cursor(`COLOR_SELECT);
        press(4);
        check_cursor(`COLOR_CURSOR);

        repeat (16) try_swap();
        read_board(seen);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (seen[r][c] == CELL_EMPTY)
                    empties++;
            end
        end
        checks++;
        assert (empties > 0) else begin
            $display("no swap ever cleared a run of three");
            errors++;
        end
        checks++;
        assert (misses > 0) else begin
            $display("no swap on the board ever ended without a run");
            errors++;
        end
        $display("swaps committed %0d, swaps without a run %0d", commits, misses);

        @(posedge clk);
        video_on <= 1'b0;
        repeat (3) @(posedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== match_top.f ====
+incdir+.
match_pkg.sv
input_controller.sv
board_store.sv
pixel_renderer.sv
match_top.sv
match_top_asserts.sv
tb_match_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the match-three testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_match_top \
        -f match_top.f -o sim_match_top; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/sim_match_top > sim.log 2>&1; then
    cat sim.log
    echo "simulation ended with an error"
    exit 1
fi

cat sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
